// ==== design/misc_cfg.svh ====
// ----------------------------------------
// Misc register block configuration
// Bus widths, region code, register index field,
// reload key and flash-select sequencer constants
// ----------------------------------------
`ifndef MISC_CFG_SVH
`define MISC_CFG_SVH

// Bus
`define MISC_ADDR_W 32
`define MISC_DATA_W 32

// Address decode, region in the top nibble
`define MISC_REGION_W 4
`define MISC_REGION_MISC 4'h2

// Register index taken from word address bits 6..2
`define MISC_IDX_W 5
`define MISC_IDX_LSB 2

// Register widths
`define MISC_GENIO_W 30
`define MISC_LED_W 16
`define MISC_BTN_W 8

// Read value for unmapped regions
`define MISC_BUSERR_DATA 32'hDEADBEEF

// Key expected in data bits 31..8 to arm the FPGA reload
`define MISC_RELOAD_KEY 24'hD0F1A5
`define MISC_RELOAD_KEY_LSB 8

// Flash-select sequencer
`define MISC_FSEL_CNT_W 3
`define MISC_FSEL_LOAD 3'd7
`define MISC_FSEL_C_HI 3'd5
`define MISC_FSEL_C_LO 3'd3

`endif

// ==== design/misc_pkg.sv ====
// ----------------------------------------
// Shared types for the misc register block
// Register index enum, region type and
// address field helpers
// ----------------------------------------
`default_nettype none

`include "misc_cfg.svh"

package misc_pkg;

	// Registers kept in the misc region
	typedef enum logic [`MISC_IDX_W-1:0] {
		REG_LED       = 5'd0,
		REG_BTN       = 5'd1,
		REG_SOC_VER   = 5'd2,
		REG_FLASH_SEL = 5'd13,
		REG_GENIO_IN  = 5'd17,
		REG_GENIO_OUT = 5'd18,
		REG_GENIO_OE  = 5'd19,
		REG_GENIO_W2S = 5'd20,
		REG_GENIO_W2C = 5'd21
	} misc_reg_e;

	// Region code from the top address nibble
	typedef logic [`MISC_REGION_W-1:0] misc_region_t;

	function automatic misc_region_t misc_addr_region(input logic [`MISC_ADDR_W-1:0] addr);
		return addr[`MISC_ADDR_W-1 -: `MISC_REGION_W];
	endfunction

	// Unnamed indices pass through the cast and read back as zero
	function automatic misc_reg_e misc_addr_idx(input logic [`MISC_ADDR_W-1:0] addr);
		return misc_reg_e'(addr[`MISC_IDX_LSB +: `MISC_IDX_W]);
	endfunction

endpackage

`default_nettype wire

// ==== design/misc_decode.sv ====
// ----------------------------------------
// Request decoder for the misc register block
// Accepts bus requests, classifies them by
// region and index, answers ready and bus error
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "misc_cfg.svh"

module misc_decode
	import misc_pkg::*;
(
	input  wire                     clk48m,
	input  wire                     rst,
	input  wire                     bus_valid_i,
	input  wire [`MISC_ADDR_W-1:0]  bus_addr_i,
	input  wire [3:0]               bus_wstrb_i,
	output logic                    acc_o,
	output logic                    wr_o,
	output misc_reg_e               reg_idx_o,
	output logic                    err_o,
	output logic                    bus_ready_o,
	output logic                    irq_bus_err_o
);

	misc_region_t region;

	// Accept only while no answer is on the bus
	assign acc_o = bus_valid_i && !bus_ready_o;

	// Any strobe bit makes it a write
	assign wr_o = |bus_wstrb_i;

	assign region    = misc_addr_region(bus_addr_i);
	assign reg_idx_o = misc_addr_idx(bus_addr_i);
	assign err_o     = (region != `MISC_REGION_MISC);

	// One-cycle answer, interrupt only for unmapped regions
	always_ff @(posedge clk48m) begin
		if (rst) begin
			bus_ready_o   <= 1'b0;
			irq_bus_err_o <= 1'b0;
		end else begin
			bus_ready_o   <= acc_o;
			irq_bus_err_o <= acc_o && err_o;
		end
	end

endmodule

`default_nettype wire

// ==== design/misc_regs.sv ====
// ----------------------------------------
// Register writer for the misc register block
// LED, trace enable, GPIO out/oe with set and
// clear, flash select and reload arming
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "misc_cfg.svh"

module misc_regs
	import misc_pkg::*;
(
	input  wire                      clk48m,
	input  wire                      rst,
	input  wire                      acc_i,
	input  wire                      wr_i,
	input  wire                      err_i,
	input  misc_reg_e                reg_idx_i,
	input  wire                      wstrb0_i,
	input  wire [`MISC_DATA_W-1:0]   wdata_i,
	output logic [`MISC_LED_W-1:0]   led_o,
	output logic                     trace_en_o,
	output logic [`MISC_GENIO_W-1:0] genio_out_o,
	output logic [`MISC_GENIO_W-1:0] genio_oe_o,
	output logic                     fsel_d_o,
	output logic                     fsel_strobe_o,
	output logic                     reload_arm_o
);

	logic                     wr_en;
	logic [`MISC_GENIO_W-1:0] genio_data;
	logic                     key_match;

	// Only byte lane 0 commits a write
	assign wr_en = acc_i && wr_i && !err_i && wstrb0_i;

	assign genio_data = wdata_i[`MISC_GENIO_W-1:0];
	assign key_match  = (wdata_i[`MISC_DATA_W-1:`MISC_RELOAD_KEY_LSB] == `MISC_RELOAD_KEY);

	always_ff @(posedge clk48m) begin
		if (rst) begin
			led_o         <= '0;
			trace_en_o    <= 1'b0;
			genio_out_o   <= '0;
			genio_oe_o    <= '0;
			fsel_d_o      <= 1'b0;
			fsel_strobe_o <= 1'b0;
			reload_arm_o  <= 1'b0;
		end else begin
			fsel_strobe_o <= 1'b0;
			if (wr_en) begin
				case (reg_idx_i)
					REG_LED: begin
						led_o <= wdata_i[`MISC_LED_W-1:0];
					end
					REG_SOC_VER: begin
						trace_en_o <= wdata_i[0];
					end
					REG_GENIO_OUT: begin
						genio_out_o <= genio_data;
					end
					REG_GENIO_OE: begin
						genio_oe_o <= genio_data;
					end
					REG_GENIO_W2S: begin
						genio_out_o <= genio_out_o | genio_data;
					end
					REG_GENIO_W2C: begin
						genio_out_o <= genio_out_o & ~genio_data;
					end
					REG_FLASH_SEL: begin
						fsel_d_o      <= wdata_i[0];
						fsel_strobe_o <= 1'b1;
						// Reload stays armed until reset
						if (key_match) begin
							reload_arm_o <= 1'b1;
						end
					end
					default: begin
						// Read-only or unmapped, nothing to store
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/misc_readback.sv ====
// ----------------------------------------
// Result stage for the misc register block
// Selects and registers the read word
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "misc_cfg.svh"

module misc_readback
	import misc_pkg::*;
(
	input  wire                      clk48m,
	input  wire                      rst,
	input  wire                      acc_i,
	input  wire                      err_i,
	input  misc_reg_e                reg_idx_i,
	input  wire [`MISC_BTN_W-1:0]    btn_i,
	input  wire [`MISC_GENIO_W-1:0]  genio_in_i,
	input  wire [`MISC_LED_W-1:0]    led_i,
	input  wire                      trace_en_i,
	input  wire [`MISC_GENIO_W-1:0]  genio_out_i,
	input  wire [`MISC_GENIO_W-1:0]  genio_oe_i,
	input  wire                      fsel_d_i,
	output logic [`MISC_DATA_W-1:0]  bus_rdata_o
);

	localparam int GPAD = `MISC_DATA_W - `MISC_GENIO_W;

	logic [`MISC_DATA_W-1:0] rd_word;

	always_comb begin
		rd_word = '0;
		if (err_i) begin
			rd_word = `MISC_BUSERR_DATA;
		end else begin
			case (reg_idx_i)
				REG_LED:       rd_word = {{(`MISC_DATA_W - `MISC_LED_W){1'b0}}, led_i};
				// Buttons are active low on the board
				REG_BTN:       rd_word = {{(`MISC_DATA_W - `MISC_BTN_W){1'b0}}, ~btn_i};
				// Version field reads 0, bit 0 shows trace enable
				REG_SOC_VER:   rd_word = {{(`MISC_DATA_W - 1){1'b0}}, trace_en_i};
				REG_FLASH_SEL: rd_word = {{(`MISC_DATA_W - 1){1'b0}}, fsel_d_i};
				REG_GENIO_IN:  rd_word = {{GPAD{1'b0}}, genio_in_i};
				REG_GENIO_OUT: rd_word = {{GPAD{1'b0}}, genio_out_i};
				REG_GENIO_OE:  rd_word = {{GPAD{1'b0}}, genio_oe_i};
				default:       rd_word = '0;
			endcase
		end
	end

	// Sampled with the accept, so a write returns the old value
	always_ff @(posedge clk48m) begin
		if (rst) begin
			bus_rdata_o <= '0;
		end else if (acc_i) begin
			bus_rdata_o <= rd_word;
		end
	end

endmodule

`default_nettype wire

// ==== design/flash_reload_seq.sv ====
// ----------------------------------------
// Flash-select clock pulse and FPGA reload
// sequencer driving fsel_c and PROGRAMN
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "misc_cfg.svh"

module flash_reload_seq (
	input  wire  clk48m,
	input  wire  rst,
	input  wire  fsel_strobe_i,
	input  wire  reload_arm_i,
	output logic fsel_c_o,
	output logic programn_o
);

	logic [`MISC_FSEL_CNT_W-1:0] fsel_cnt;
	logic                        reload;

	// Clock the select flop in the middle of the count so fsel_d has settled
	assign fsel_c_o = (fsel_cnt <= `MISC_FSEL_C_HI) && (fsel_cnt >= `MISC_FSEL_C_LO);

	assign programn_o = ~reload;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			fsel_cnt <= '0;
			reload   <= 1'b0;
		end else if (fsel_strobe_i) begin
			fsel_cnt <= `MISC_FSEL_LOAD;
		end else if (fsel_cnt != '0) begin
			fsel_cnt <= fsel_cnt - 1'b1;
			// Pull PROGRAMN only after the select pulse is done
			if (fsel_cnt == 'd1 && reload_arm_i) begin
				reload <= 1'b1;
			end
		end
	end

	// Select pulse is three cycles wide, starting three cycles after the strobe
	a_fsel_c_pulse: assert property (
		@(posedge clk48m) disable iff (rst)
		fsel_strobe_i |-> ##3 fsel_c_o [*3] ##1 !fsel_c_o
	);

endmodule

`default_nettype wire

// ==== design/misc_top.sv ====
// ----------------------------------------
// Misc register block top level
// Decoder, register writer, readback stage
// and flash reload sequencer
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "misc_cfg.svh"

module misc_top
	import misc_pkg::*;
(
	input  wire                      clk48m,
	input  wire                      rst,
	input  wire                      bus_valid_i,
	input  wire [`MISC_ADDR_W-1:0]   bus_addr_i,
	input  wire [`MISC_DATA_W-1:0]   bus_wdata_i,
	input  wire [3:0]                bus_wstrb_i,
	output wire                      bus_ready_o,
	output wire [`MISC_DATA_W-1:0]   bus_rdata_o,
	input  wire [`MISC_BTN_W-1:0]    btn_i,
	input  wire [`MISC_GENIO_W-1:0]  genio_in_i,
	output wire [`MISC_LED_W-1:0]    led_o,
	output wire                      trace_en_o,
	output wire [`MISC_GENIO_W-1:0]  genio_out_o,
	output wire [`MISC_GENIO_W-1:0]  genio_oe_o,
	output wire                      fsel_d_o,
	output wire                      fsel_c_o,
	output wire                      programn_o,
	output wire                      irq_bus_err_o
);

	wire       acc;
	wire       wr;
	wire       err;
	misc_reg_e reg_idx;
	wire       fsel_strobe;
	wire       reload_arm;

	misc_decode u_misc_decode (
		.clk48m        (clk48m),
		.rst           (rst),
		.bus_valid_i   (bus_valid_i),
		.bus_addr_i    (bus_addr_i),
		.bus_wstrb_i   (bus_wstrb_i),
		.acc_o         (acc),
		.wr_o          (wr),
		.reg_idx_o     (reg_idx),
		.err_o         (err),
		.bus_ready_o   (bus_ready_o),
		.irq_bus_err_o (irq_bus_err_o)
	);

	misc_regs u_misc_regs (
		.clk48m        (clk48m),
		.rst           (rst),
		.acc_i         (acc),
		.wr_i          (wr),
		.err_i         (err),
		.reg_idx_i     (reg_idx),
		.wstrb0_i      (bus_wstrb_i[0]),
		.wdata_i       (bus_wdata_i),
		.led_o         (led_o),
		.trace_en_o    (trace_en_o),
		.genio_out_o   (genio_out_o),
		.genio_oe_o    (genio_oe_o),
		.fsel_d_o      (fsel_d_o),
		.fsel_strobe_o (fsel_strobe),
		.reload_arm_o  (reload_arm)
	);

	misc_readback u_misc_readback (
		.clk48m      (clk48m),
		.rst         (rst),
		.acc_i       (acc),
		.err_i       (err),
		.reg_idx_i   (reg_idx),
		.btn_i       (btn_i),
		.genio_in_i  (genio_in_i),
		.led_i       (led_o),
		.trace_en_i  (trace_en_o),
		.genio_out_i (genio_out_o),
		.genio_oe_i  (genio_oe_o),
		.fsel_d_i    (fsel_d_o),
		.bus_rdata_o (bus_rdata_o)
	);

	flash_reload_seq u_flash_reload_seq (
		.clk48m        (clk48m),
		.rst           (rst),
		.fsel_strobe_i (fsel_strobe),
		.reload_arm_i  (reload_arm),
		.fsel_c_o      (fsel_c_o),
		.programn_o    (programn_o)
	);

endmodule

`default_nettype wire

// ==== verif/misc_checker.sv ====
// ----------------------------------------
// Checker for the misc register block
// Compares DUT ports with the testbench model
// each clock and keeps the error counts
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "misc_cfg.svh"

module misc_checker (
	input  wire                      clk48m,
	input  wire                      rst,
	input  wire                      bus_valid_i,
	input  wire                      bus_ready_i,
	input  wire [`MISC_DATA_W-1:0]   bus_rdata_i,
	input  wire                      irq_bus_err_i,
	input  wire [`MISC_LED_W-1:0]    led_i,
	input  wire                      trace_en_i,
	input  wire [`MISC_GENIO_W-1:0]  genio_out_i,
	input  wire [`MISC_GENIO_W-1:0]  genio_oe_i,
	input  wire                      fsel_d_i,
	input  wire                      fsel_c_i,
	input  wire                      programn_i,
	input  wire [`MISC_DATA_W-1:0]   exp_rdata_i,
	input  wire                      exp_err_i,
	input  wire [`MISC_LED_W-1:0]    exp_led_i,
	input  wire                      exp_trace_i,
	input  wire [`MISC_GENIO_W-1:0]  exp_genio_out_i,
	input  wire [`MISC_GENIO_W-1:0]  exp_genio_oe_i,
	input  wire                      exp_fsel_d_i,
	input  wire                      exp_fsel_c_i,
	input  wire                      exp_programn_i,
	input  wire                      test_done_i,
	input  wire [7:0]                test_id_i,
	input  wire                      all_done_i,
	output wire [31:0]               err_cnt_o
);

	int   checks = 0;
	int   errors = 0;
	int   test_errors = 0;
	int   tests = 0;
	logic pend;

	assign err_cnt_o = errors;

	task automatic compare(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("Fail time %0t %0s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// Values just before the edge are stable, the DUT updates on it
	always @(posedge clk48m) begin
		if (rst) begin
			pend <= 1'b0;
		end else begin
			// Ready follows an accept by exactly one cycle
			compare("bus_ready_o", bus_ready_i, pend);
			if (pend) begin
				compare("bus_rdata_o", bus_rdata_i, exp_rdata_i);
			end
			compare("irq_bus_err_o", irq_bus_err_i, pend && exp_err_i);
			compare("led_o", led_i, exp_led_i);
			compare("trace_en_o", trace_en_i, exp_trace_i);
			compare("genio_out_o", genio_out_i, exp_genio_out_i);
			compare("genio_oe_o", genio_oe_i, exp_genio_oe_i);
			compare("fsel_d_o", fsel_d_i, exp_fsel_d_i);
			compare("fsel_c_o", fsel_c_i, exp_fsel_c_i);
			compare("programn_o", programn_i, exp_programn_i);
			pend <= bus_valid_i && !pend;
		end
		if (test_done_i) begin
			tests++;
			$display("test %0d finished with %0d errors", test_id_i, test_errors);
			test_errors = 0;
		end
		if (all_done_i) begin
			$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		end
	end

endmodule

`default_nettype wire

// ==== verif/misc_tb.sv ====
// ----------------------------------------
// Testbench for the misc register block
// Clock, reset, seeded random bus traffic
// and the reference register model
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "misc_cfg.svh"

module misc_tb
	import misc_pkg::*;
();

	localparam int READY_TIMEOUT = 20;

	logic                     clk48m;
	logic                     rst;
	logic                     bus_valid;
	logic [31:0]              bus_addr;
	logic [31:0]              bus_wdata;
	logic [3:0]               bus_wstrb;
	logic [`MISC_BTN_W-1:0]   btn;
	logic [`MISC_GENIO_W-1:0] genio_in;
	integer                   seed;

	wire                      bus_ready;
	wire [31:0]               bus_rdata;
	wire [`MISC_LED_W-1:0]    led;
	wire                      trace_en;
	wire [`MISC_GENIO_W-1:0]  genio_out;
	wire [`MISC_GENIO_W-1:0]  genio_oe;
	wire                      fsel_d;
	wire                      fsel_c;
	wire                      programn;
	wire                      irq_bus_err;
	wire [31:0]               err_cnt;

	// Reference model
	logic [31:0]              exp_rdata;
	logic                     exp_err;
	logic [`MISC_LED_W-1:0]   m_led;
	logic                     m_trace;
	logic [`MISC_GENIO_W-1:0] m_gout;
	logic [`MISC_GENIO_W-1:0] m_goe;
	logic                     m_fsel_d;
	logic                     m_fsel_c;
	logic                     m_programn;
	logic                     m_armed;
	logic                     test_done;
	logic [7:0]               test_id;
	logic                     all_done;

	misc_top u_misc_top (
		.clk48m        (clk48m),
		.rst           (rst),
		.bus_valid_i   (bus_valid),
		.bus_addr_i    (bus_addr),
		.bus_wdata_i   (bus_wdata),
		.bus_wstrb_i   (bus_wstrb),
		.bus_ready_o   (bus_ready),
		.bus_rdata_o   (bus_rdata),
		.btn_i         (btn),
		.genio_in_i    (genio_in),
		.led_o         (led),
		.trace_en_o    (trace_en),
		.genio_out_o   (genio_out),
		.genio_oe_o    (genio_oe),
		.fsel_d_o      (fsel_d),
		.fsel_c_o      (fsel_c),
		.programn_o    (programn),
		.irq_bus_err_o (irq_bus_err)
	);

	misc_checker u_misc_checker (
		.clk48m          (clk48m),
		.rst             (rst),
		.bus_valid_i     (bus_valid),
		.bus_ready_i     (bus_ready),
		.bus_rdata_i     (bus_rdata),
		.irq_bus_err_i   (irq_bus_err),
		.led_i           (led),
		.trace_en_i      (trace_en),
		.genio_out_i     (genio_out),
		.genio_oe_i      (genio_oe),
		.fsel_d_i        (fsel_d),
		.fsel_c_i        (fsel_c),
		.programn_i      (programn),
		.exp_rdata_i     (exp_rdata),
		.exp_err_i       (exp_err),
		.exp_led_i       (m_led),
		.exp_trace_i     (m_trace),
		.exp_genio_out_i (m_gout),
		.exp_genio_oe_i  (m_goe),
		.exp_fsel_d_i    (m_fsel_d),
		.exp_fsel_c_i    (m_fsel_c),
		.exp_programn_i  (m_programn),
		.test_done_i     (test_done),
		.test_id_i       (test_id),
		.all_done_i      (all_done),
		.err_cnt_o       (err_cnt)
	);

	initial begin
		clk48m = 1'b0;
		forever #4 clk48m = ~clk48m;
	end

	// ----------------------------------------
	// Model rules
	// ----------------------------------------
	function automatic logic [31:0] model_read(input logic [4:0] idx);
		case (idx)
			REG_LED:       return {16'h0, m_led};
			REG_BTN:       return {24'h0, ~btn};
			REG_SOC_VER:   return {31'h0, m_trace};
			REG_FLASH_SEL: return {31'h0, m_fsel_d};
			REG_GENIO_IN:  return {2'b00, genio_in};
			REG_GENIO_OUT: return {2'b00, m_gout};
			REG_GENIO_OE:  return {2'b00, m_goe};
			default:       return 32'h0;
		endcase
	endfunction

	function automatic logic is_mapped(input logic [4:0] idx);
		return idx inside {5'd0, 5'd1, 5'd2, 5'd13, 5'd17, 5'd18, 5'd19, 5'd20, 5'd21};
	endfunction

	// Random address inside region 2 that hits the given index
	function automatic logic [31:0] misc_addr(input logic [4:0] idx);
		logic [31:0] a;
		a = $random(seed);
		a[31:28] = `MISC_REGION_MISC;
		a[6:2] = idx;
		return a;
	endfunction

	task automatic apply_write(input logic [4:0] idx, input logic [31:0] data,
			input logic [3:0] strobe);
		if (strobe[0]) begin
			case (idx)
				REG_LED:       m_led = data[15:0];
				REG_SOC_VER:   m_trace = data[0];
				REG_GENIO_OUT: m_gout = data[29:0];
				REG_GENIO_OE:  m_goe = data[29:0];
				REG_GENIO_W2S: m_gout = m_gout | data[29:0];
				REG_GENIO_W2C: m_gout = m_gout & ~data[29:0];
				REG_FLASH_SEL: begin
					m_fsel_d = data[0];
					if (data[31:8] == `MISC_RELOAD_KEY) begin
						m_armed = 1'b1;
					end
				end
				default: begin
				end
			endcase
		end
	endtask

	// ----------------------------------------
	// Bus driving
	// ----------------------------------------
	task automatic bus_cycle(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strobe, input logic [31:0] exp_rd, input logic exp_e);
		int waited;
		@(negedge clk48m);
		bus_valid = 1'b1;
		bus_addr  = addr;
		bus_wdata = data;
		bus_wstrb = strobe;
		exp_rdata = exp_rd;
		exp_err   = exp_e;
		waited = 0;
		@(negedge clk48m);
		while (!bus_ready && waited < READY_TIMEOUT) begin
			waited++;
			@(negedge clk48m);
		end
		if (!bus_ready) begin
			$display("No ready from the DUT within %0d cycles for address %h",
				READY_TIMEOUT, addr);
			$display("tests failed");
			$finish;
		end else begin
			bus_valid = 1'b0;
			bus_wstrb = 4'h0;
		end
	endtask

	// A write answers with the value from before the write
	task automatic reg_access(input logic [4:0] idx, input logic [31:0] data,
			input logic [3:0] strobe);
		bus_cycle(misc_addr(idx), data, strobe, model_read(idx), 1'b0);
		apply_write(idx, data, strobe);
	endtask

	// Steps the model through the select pulse and reload timing
	task automatic flash_write(input logic [31:0] data);
		int m;
		reg_access(REG_FLASH_SEL, data, 4'($random(seed)) | 4'h1);
		for (m = 2; m <= 11; m++) begin
			@(negedge clk48m);
			m_fsel_c = (m >= 4 && m <= 6);
			if (m_armed && m >= 9) begin
				m_programn = 1'b0;
			end
		end
	endtask

	task automatic end_test(input logic [7:0] id);
		@(negedge clk48m);
		test_id = id;
		test_done = 1'b1;
		@(negedge clk48m);
		test_done = 1'b0;
	endtask

	initial begin : stimulus
		int          i;
		logic [31:0] r;
		logic [31:0] data;
		logic [4:0]  idx;
		seed = 65661;
		rst = 1'b1;
		bus_valid = 1'b0;
		bus_addr = 32'h0;
		bus_wdata = 32'h0;
		bus_wstrb = 4'h0;
		btn = '0;
		genio_in = '0;
		exp_rdata = 32'h0;
		exp_err = 1'b0;
		m_led = '0;
		m_trace = 1'b0;
		m_gout = '0;
		m_goe = '0;
		m_fsel_d = 1'b0;
		m_fsel_c = 1'b0;
		m_programn = 1'b1;
		m_armed = 1'b0;
		test_done = 1'b0;
		test_id = 8'd0;
		all_done = 1'b0;
		repeat (3) @(posedge clk48m);
		@(negedge clk48m);
		rst = 1'b0;

		// Read/write registers with random strobes
		for (i = 0; i < 60; i++) begin
			r = $random(seed);
			case (r[1:0])
				2'd0: idx = REG_LED;
				2'd1: idx = REG_SOC_VER;
				2'd2: idx = REG_GENIO_OUT;
				default: idx = REG_GENIO_OE;
			endcase
			reg_access(idx, $random(seed), r[2] ? r[7:4] : 4'h0);
		end
		end_test(8'd1);

		// GPIO set and clear
		for (i = 0; i < 40; i++) begin
			r = $random(seed);
			idx = r[0] ? REG_GENIO_W2S : REG_GENIO_W2C;
			reg_access(idx, $random(seed), r[7:4] | 4'h1);
			if (r[1]) begin
				reg_access(REG_GENIO_OUT, 32'h0, 4'h0);
			end
		end
		end_test(8'd2);

		// Inputs and unmapped indices
		for (i = 0; i < 40; i++) begin
			r = $random(seed);
			btn = $random(seed);
			genio_in = $random(seed);
			if (r[1:0] == 2'd0) begin
				idx = $random(seed);
				while (is_mapped(idx)) begin
					idx = idx + 1'b1;
				end
			end else begin
				idx = r[0] ? REG_BTN : REG_GENIO_IN;
			end
			reg_access(idx, 32'h0, 4'h0);
		end
		end_test(8'd3);

		// Regions other than the misc region
		for (i = 0; i < 30; i++) begin
			r = $random(seed);
			if (r[31:28] == `MISC_REGION_MISC) begin
				r[31:28] = 4'hA;
			end
			bus_cycle(r, $random(seed), 4'($random(seed)), `MISC_BUSERR_DATA, 1'b1);
		end
		end_test(8'd4);

		// Flash select without and then with the reload key
		data = $random(seed);
		if (data[31:8] == `MISC_RELOAD_KEY) begin
			data[31:8] = ~data[31:8];
		end
		data[0] = 1'b1;
		flash_write(data);
		reg_access(REG_FLASH_SEL, 32'h0, 4'h0);
		data = {`MISC_RELOAD_KEY, 8'($random(seed))};
		data[0] = 1'b0;
		flash_write(data);
		for (i = 0; i < 4; i++) begin
			reg_access(REG_FLASH_SEL, 32'h0, 4'h0);
		end
		end_test(8'd5);

		@(negedge clk48m);
		all_done = 1'b1;
		@(negedge clk48m);
		all_done = 1'b0;
		if (err_cnt == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+design
design/misc_pkg.sv
design/misc_decode.sv
design/misc_regs.sv
design/misc_readback.sv
design/flash_reload_seq.sv
design/misc_top.sv
verif/misc_checker.sv
verif/misc_tb.sv
